// File: Bender.yml
package:
  name: spi_eebuf

sources:
  - verilog/spi_ee_pkg.sv
  - verilog/ee_array_pkg.sv
  - verilog/spi_din_shift.sv
  - verilog/ee_addr_track.sv
  - verilog/ee_rd_ctrl.sv
  - verilog/ee_wr_cnt.sv
  - verilog/ee_word_merge.sv
  - verilog/ee_pump_ctrl.sv
  - verilog/spi_eebuf_top.sv
  - target: test
    files:
      - verification/spi_eebuf_chk.sv
      - verification/tb_spi_eebuf.sv

// File: project.f
verilog/spi_ee_pkg.sv
verilog/ee_array_pkg.sv
verilog/spi_din_shift.sv
verilog/ee_addr_track.sv
verilog/ee_rd_ctrl.sv
verilog/ee_wr_cnt.sv
verilog/ee_word_merge.sv
verilog/ee_pump_ctrl.sv
verilog/spi_eebuf_top.sv
verification/spi_eebuf_chk.sv
verification/tb_spi_eebuf.sv

// File: verification/spi_eebuf_chk.sv
// Strobe checks for the SPI EEPROM data buffer
// Bound into the buffer top level
module spi_eebuf_chk (
    input logic spi_clk_c,
    input logic spi_frm_rst_n,
    input logic spi_rd_en,
    input logic spi_rdbuf_en,
    input logic spi_cin,
    input logic spi_d_active
);

    // Old word comes from one place only
    a_rd_excl: assert property (@(posedge spi_clk_c) disable iff (!spi_frm_rst_n)
        !(spi_rd_en && spi_rdbuf_en)) else $error("array and page buffer pre-read together");

    // Pre-read window is two bit times
    a_rd_len: assert property (@(posedge spi_clk_c) disable iff (!spi_frm_rst_n)
        (spi_rd_en || spi_rdbuf_en) && $past(spi_rd_en || spi_rdbuf_en)
        |-> !$past(spi_rd_en || spi_rdbuf_en, 2)) else $error("pre-read strobe too long");

    // Page byte end runs into the next byte head, so two cycles at most
    a_dact_len: assert property (@(posedge spi_clk_c) disable iff (!spi_frm_rst_n)
        spi_d_active && $past(spi_d_active) |-> !$past(spi_d_active, 2))
        else $error("data-active held too long");

    // Carry-in low for bit 0, 7 and 6 of back to back page bytes
    a_cin_len: assert property (@(posedge spi_clk_c) disable iff (!spi_frm_rst_n)
        !spi_cin && !$past(spi_cin) && !$past(spi_cin, 2) |-> $past(spi_cin, 3))
        else $error("carry-in held low too long");

endmodule

bind spi_eebuf_top spi_eebuf_chk u_chk (.*);

// File: verification/tb_spi_eebuf.sv
// Testbench for the SPI EEPROM data buffer
// LFSR driven frames checked cycle by cycle against a reference model
module tb_spi_eebuf;
    import spi_ee_pkg::*;
    import ee_array_pkg::*;

    localparam int N_FRAMES  = 40;
    localparam int MAX_BYTES = 16;     // Data bytes per frame, upper bound
    localparam int LIMIT     = 8 + N_FRAMES * (3 + MAX_BYTES) * BYTE_W + 100;

    logic                 spi_clk_c;
    logic                 spi_frm_rst_n;
    spi_state_t           spi_curr_state;
    logic [BIT_CNT_W-1:0] spi_bit_cnt;
    logic [LANE_W-1:0]    spi_byte_cnt;
    logic [EE_ADDR_W-1:0] spi_curr_addr;
    logic                 sda_in, spi_ee_wbusy, spi_cmd_read, spi_valid;
    logic [EE_WORD_W-1:0] spi_data_in;
    logic                 spi_rd_en, spi_rdbuf_en, spi_cin, spi_d_active, spi_clr_dl, spi_vs_en;
    logic [EE_ADDR_W-1:0] spi_ee_addr;
    logic [EE_WORD_W-1:0] spi_data_out;

    // Model state, value expected after the coming edge
    logic [EE_ADDR_W-1:0] m_addr;
    logic [EE_WORD_W-1:0] m_data;
    logic                 m_strb, m_pre, m_roll, m_cin, m_dact, m_clr;
    logic [WR_CNT_W-1:0]  m_cnt;           // Written bytes, saturating
    logic [LANE_W-1:0]    m_lane;          // Lane latched at byte write bit 6
    logic [15:0]          lfsr_q;
    int                   errors, checks, cycles, rdbuf_seen;

    spi_eebuf_top u_dut (.*);

    initial begin
        spi_clk_c = 1'b0;
        forever #4 spi_clk_c = ~spi_clk_c;
    end

    always @(posedge spi_clk_c) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, frames did not complete", cycles);
            $display("test failed");
            $finish;
        end
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);   // One step per bit
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        errors++;
        $display("FAIL %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cycles);
    endtask

    task automatic check_reset();
        checks += 8;
        if (spi_rd_en !== 1'b0) report_mismatch("spi_rd_en", spi_rd_en, 0);
        if (spi_rdbuf_en !== 1'b0) report_mismatch("spi_rdbuf_en", spi_rdbuf_en, 0);
        if (spi_cin !== 1'b1) report_mismatch("spi_cin", spi_cin, 1);
        if (spi_d_active !== 1'b0) report_mismatch("spi_d_active", spi_d_active, 0);
        if (spi_clr_dl !== 1'b1) report_mismatch("spi_clr_dl", spi_clr_dl, 1);
        if (spi_vs_en !== 1'b0) report_mismatch("spi_vs_en", spi_vs_en, 0);
        if (spi_ee_addr !== 16'h0) report_mismatch("spi_ee_addr", spi_ee_addr, 0);
        if (spi_data_out !== 32'hFFFF_FFFF) report_mismatch("spi_data_out", spi_data_out, '1);
    endtask

    task automatic check_regs();
        logic exp_rd;
        logic exp_buf;
        exp_rd  = m_strb && !m_roll;       // Array side before page end
        exp_buf = m_strb && m_roll;
        checks += 7;
        if (spi_rdbuf_en) rdbuf_seen++;
        if (spi_ee_addr !== m_addr) report_mismatch("spi_ee_addr", spi_ee_addr, m_addr);
        if (spi_data_out !== m_data) report_mismatch("spi_data_out", spi_data_out, m_data);
        if (spi_rd_en !== exp_rd) report_mismatch("spi_rd_en", spi_rd_en, exp_rd);
        if (spi_rdbuf_en !== exp_buf) report_mismatch("spi_rdbuf_en", spi_rdbuf_en, exp_buf);
        if (spi_cin !== m_cin) report_mismatch("spi_cin", spi_cin, m_cin);
        if (spi_d_active !== m_dact) report_mismatch("spi_d_active", spi_d_active, m_dact);
        if (spi_clr_dl !== m_clr) report_mismatch("spi_clr_dl", spi_clr_dl, m_clr);
    endtask

    // ********************
    // Reference model, one rising edge with the inputs now driven
    task automatic model_clock(logic [BYTE_W-1:0] tx);
        spi_state_t           st;
        logic [2:0]           b;
        logic [1:0]           ln;
        logic                 wr;
        logic [EE_WORD_W-1:0] bg;
        st = spi_curr_state;
        b  = spi_bit_cnt;
        ln = spi_curr_addr[1:0];
        wr = (st == SPI_BYTE_WR) || (st == SPI_PAGE_WR);
        if (wr && b == 5)
            m_addr = spi_curr_addr;                             // Reload per byte
        else if (st == SPI_ADDR_HB && b == 0)
            m_addr = {spi_curr_addr[6:0], sda_in, 8'h00};
        else if (st == SPI_ADDR_LB && b == 0)
            m_addr = {spi_curr_addr[12:0], sda_in, 2'b00};
        else if (st == SPI_DAT_RD && ln == 2'd3 && !spi_ee_wbusy)
            m_addr = spi_curr_addr + 16'd1;
        if (wr && b == 0) begin
            bg = m_pre ? spi_data_in : m_data;                  // Old word behind the byte
            bg[8 * spi_byte_cnt +: 8] = tx;
            m_data = bg;
        end
        if (b == 0)
            m_pre = 1'b0;
        else if (m_strb && (wr || st == SPI_ADDR_LB))
            m_pre = 1'b1;
        case (st)
            SPI_ADDR_LB: m_strb = spi_cmd_read && (b == 1 || b == 2);
            SPI_DAT_RD:  m_strb = (ln == 2'd3) && (b == 3 || b == 4);
            SPI_BYTE_WR: m_strb = (b == 3 || b == 4);
            SPI_PAGE_WR: m_strb = (ln == 2'd0) && (b == 3 || b == 4);
            default:     m_strb = 1'b0;
        endcase
        m_roll = (m_cnt >= PAGE_BYTES - 1 - m_lane);           // Old count and lane
        if (wr && b == 0 && m_cnt < 255) m_cnt++;
        if (st == SPI_BYTE_WR && b == 6) m_lane = ln;
        m_cin  = !((st == SPI_BYTE_WR && b == 0) || (st == SPI_CMD && b == 7)
                   || (st == SPI_PAGE_WR && (b == 0 || b == 6 || b == 7)));
        m_dact = (st == SPI_BYTE_WR && b == 0) || (st == SPI_PAGE_WR && (b == 0 || b == 7));
        m_clr  = (st == SPI_CMD) && !spi_ee_wbusy && (b == 5 || b == 6);
    endtask

    // ********************
    // Stimulus, set just after the falling edge
    task automatic tick(spi_state_t st, logic [BIT_CNT_W-1:0] b, logic [BYTE_W-1:0] tx,
                        logic [EE_ADDR_W-1:0] addr, logic [EE_WORD_W-1:0] word);
        logic exp_vs;
        spi_curr_state = st;
        spi_bit_cnt    = b;
        sda_in         = tx[b];
        spi_curr_addr  = addr;
        spi_byte_cnt   = addr[LANE_W-1:0];
        spi_data_in    = word;
        spi_ee_wbusy   = 1'(rand_bits(1));
        spi_valid      = 1'(rand_bits(1));
        #1;
        exp_vs = spi_valid && !m_clr && !spi_ee_wbusy;       // Combinational gate
        checks++;
        if (spi_vs_en !== exp_vs) report_mismatch("spi_vs_en", spi_vs_en, exp_vs);
        model_clock(tx);
        @(negedge spi_clk_c);
        check_regs();
    endtask

    task automatic send_byte(spi_state_t st, logic [EE_ADDR_W-1:0] addr);
        logic [BYTE_W-1:0]    tx;
        logic [EE_WORD_W-1:0] word;
        tx   = 8'(rand_bits(BYTE_W));
        word = rand_bits(EE_WORD_W);      // Array word offered for pre-read
        for (int i = BYTE_W - 1; i >= 0; i--)
            tick(st, BIT_CNT_W'(i), tx, addr, word);
    endtask

    task automatic run_frame();
        logic [1:0]           kind;
        logic [EE_ADDR_W-1:0] base;
        int                   n;
        spi_state_t           dst;
        kind = 2'(rand_bits(2));
        n    = 1 + rand_bits(4);
        base = 16'(rand_bits(EE_ADDR_W));
        dst  = (kind == 2'd0) ? SPI_BYTE_WR : (kind == 2'd2) ? SPI_DAT_RD : SPI_PAGE_WR;
        spi_cmd_read = (dst == SPI_DAT_RD);
        send_byte(SPI_CMD, base);
        send_byte(SPI_ADDR_HB, base);
        send_byte(SPI_ADDR_LB, base);
        for (int i = 0; i < n; i++)
            send_byte(dst, base + EE_ADDR_W'(i));                // Running address per byte
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        rdbuf_seen = 0;
        lfsr_q     = 16'd34515;
        spi_frm_rst_n  = 1'b0;
        spi_curr_state = SPI_WAIT;
        spi_bit_cnt    = 3'd7;
        spi_byte_cnt   = '0;
        spi_curr_addr  = '0;
        sda_in         = 1'b0;
        spi_ee_wbusy   = 1'b0;
        spi_cmd_read   = 1'b0;
        spi_valid      = 1'b0;
        spi_data_in    = '0;
        m_addr = '0;
        m_data = '1;
        m_strb = 1'b0;
        m_pre  = 1'b0;
        m_roll = 1'b0;
        m_cin  = 1'b1;
        m_dact = 1'b0;
        m_clr  = 1'b1;
        m_cnt  = '0;
        m_lane = '0;
        repeat (8) @(negedge spi_clk_c);
        spi_frm_rst_n = 1'b1;
        check_reset();
        for (int f = 0; f < N_FRAMES; f++)
            run_frame();
        if (rdbuf_seen == 0) begin
            errors++;
            $display("No pre-read strobe was ever routed to the page buffer");
        end
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: verilog/ee_addr_track.sv
// Array address register
// Built from two address bytes, reloaded per written byte,
// stepped past each full word during reads
module ee_addr_track (
    input  logic                                  spi_clk_c,
    input  logic                                  spi_frm_rst_n,
    input  spi_ee_pkg::spi_state_t                spi_curr_state,
    input  logic [spi_ee_pkg::BIT_CNT_W-1:0]      spi_bit_cnt,
    input  logic [ee_array_pkg::EE_ADDR_W-1:0]    spi_curr_addr,
    input  logic                                  sda_in,
    input  logic                                  spi_ee_wbusy,
    output logic [ee_array_pkg::EE_ADDR_W-1:0]    spi_ee_addr
);
    import spi_ee_pkg::*;
    import ee_array_pkg::*;

    logic last_bit;     // Bit 0 of current byte
    logic word_end;     // Read pointer on lane 3

    assign last_bit = (spi_bit_cnt == BIT_0);
    assign word_end = &spi_curr_addr[LANE_W-1:0];

    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            spi_ee_addr <= '0;
        end else if (is_wr_state(spi_curr_state) && spi_bit_cnt == BIT_5) begin
            spi_ee_addr <= spi_curr_addr;       // Reload mid byte
        end else if (spi_curr_state == SPI_ADDR_HB && last_bit) begin
            // High byte, parked in the upper half
            spi_ee_addr <= {spi_curr_addr[EE_ADDR_W-10:0], sda_in, 8'd0};
        end else if (spi_curr_state == SPI_ADDR_LB && last_bit) begin
            // Low byte lands above the two lane bits
            spi_ee_addr <= {spi_curr_addr[EE_ADDR_W-4:0], sda_in, 2'd0};
        end else if (spi_curr_state == SPI_DAT_RD && word_end && !spi_ee_wbusy) begin
            spi_ee_addr <= spi_curr_addr + 16'd1;    // Next word
        end
    end

endmodule

// File: verilog/ee_array_pkg.sv
// EEPROM array geometry
// Address and word widths, page length and the word/lane view
package ee_array_pkg;

    localparam int EE_ADDR_W  = 16;             // Byte address
    localparam int EE_WORD_W  = 32;             // Array word
    localparam int LANE_W     = 2;              // Byte lane select bits
    localparam int EE_LANES   = 1 << LANE_W;    // Bytes per word
    localparam int PAGE_BYTES = 128;            // Page length for roll-over
    localparam int WR_CNT_W   = 8;              // Page-write byte counter

    // ********************
    // One array word, seen whole or lane by lane
    // Lane 0 is the low byte
    typedef union packed {
        logic [EE_WORD_W-1:0]                         word;
        logic [EE_LANES-1:0][EE_WORD_W/EE_LANES-1:0]  lane;
    } ee_word_u;

endpackage

// File: verilog/ee_pump_ctrl.sv
// Write pump and data latch strobes
// One-cycle pulses from state and bit position, plus gated valid
module ee_pump_ctrl (
    input  logic                                  spi_clk_c,
    input  logic                                  spi_frm_rst_n,
    input  spi_ee_pkg::spi_state_t                spi_curr_state,
    input  logic [spi_ee_pkg::BIT_CNT_W-1:0]      spi_bit_cnt,
    input  logic                                  spi_valid,
    input  logic                                  spi_ee_wbusy,
    output logic                                  spi_cin,
    output logic                                  spi_d_active,
    output logic                                  spi_clr_dl,
    output logic                                  spi_vs_en
);
    import spi_ee_pkg::*;

    logic byte_end;     // BYTE_WR bit 0
    logic page_end;     // PAGE_WR bit 0
    logic page_head;    // PAGE_WR bit 7
    logic cin_req;      // Carry-in pulse wanted, active low out
    logic clr_req;      // Latch clear wanted

    assign byte_end  = (spi_curr_state == SPI_BYTE_WR) && (spi_bit_cnt == BIT_0);
    assign page_end  = (spi_curr_state == SPI_PAGE_WR) && (spi_bit_cnt == BIT_0);
    assign page_head = (spi_curr_state == SPI_PAGE_WR) && (spi_bit_cnt == BIT_7);

    assign cin_req = byte_end || page_end || page_head
                  || ((spi_curr_state == SPI_PAGE_WR) && (spi_bit_cnt == BIT_6))
                  || ((spi_curr_state == SPI_CMD) && (spi_bit_cnt == BIT_7));

    // Clear only while the array is idle
    assign clr_req = (spi_curr_state == SPI_CMD) && !spi_ee_wbusy
                  && ((spi_bit_cnt == BIT_5) || (spi_bit_cnt == BIT_6));

    // ********************
    // Strobe registers, cin and clr_dl idle high
    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            spi_cin      <= 1'b1;
            spi_d_active <= 1'b0;
            spi_clr_dl   <= 1'b1;
        end else begin
            spi_cin      <= !cin_req;
            spi_d_active <= byte_end || page_end || page_head;
            spi_clr_dl   <= clr_req;
        end
    end

    // Valid blocked during a clear or a busy array
    assign spi_vs_en = spi_valid && !spi_clr_dl && !spi_ee_wbusy;

endmodule

// File: verilog/ee_rd_ctrl.sv
// Pre-read strobe control
// Fetches the old word ahead of a merge or a read byte,
// sends it to the array or to the page buffer after roll-over
module ee_rd_ctrl (
    input  logic                                  spi_clk_c,
    input  logic                                  spi_frm_rst_n,
    input  spi_ee_pkg::spi_state_t                spi_curr_state,
    input  logic [spi_ee_pkg::BIT_CNT_W-1:0]      spi_bit_cnt,
    input  logic [ee_array_pkg::LANE_W-1:0]       lane,
    input  logic                                  spi_cmd_read,
    input  logic                                  wr_roll_over,
    output logic                                  spi_rd_en,
    output logic                                  spi_rdbuf_en,
    output logic                                  preread_state
);
    import spi_ee_pkg::*;

    logic bit_12;       // Early window, address phase
    logic bit_34;       // Mid byte window, data phases
    logic rd_req;       // Strobe condition this cycle
    logic rd_strb;      // Registered pre-read strobe

    assign bit_12 = (spi_bit_cnt == BIT_1) || (spi_bit_cnt == BIT_2);
    assign bit_34 = (spi_bit_cnt == BIT_3) || (spi_bit_cnt == BIT_4);

    // ********************
    // Trigger decode
    always_comb begin
        rd_req = 1'b0;
        case (spi_curr_state)
            SPI_ADDR_LB: rd_req = spi_cmd_read && bit_12;   // First read word
            SPI_DAT_RD:  rd_req = (&lane) && bit_34;        // Word about to end
            SPI_BYTE_WR: rd_req = bit_34;                   // Every byte write
            SPI_PAGE_WR: rd_req = !(|lane) && bit_34;       // Word start only
            default:     rd_req = 1'b0;
        endcase
    end

    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            rd_strb <= 1'b0;
        end else begin
            rd_strb <= rd_req;
        end
    end

    // Past the page end the old data sits in the page buffer
    assign spi_rd_en    = rd_strb && !wr_roll_over;
    assign spi_rdbuf_en = rd_strb && wr_roll_over;

    // ********************
    // Array word valid for the merge of this byte
    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            preread_state <= 1'b0;
        end else if (spi_bit_cnt == BIT_0) begin
            preread_state <= 1'b0;              // Consumed at byte end
        end else if (rd_strb &&
                     (is_wr_state(spi_curr_state) || spi_curr_state == SPI_ADDR_LB)) begin
            preread_state <= 1'b1;
        end
    end

endmodule

// File: verilog/ee_word_merge.sv
// Write word merge
// Drops each written byte into its lane of the 32-bit array word,
// rest of the word from the pre-read or the last merged value
module ee_word_merge (
    input  logic                                  spi_clk_c,
    input  logic                                  spi_frm_rst_n,
    input  spi_ee_pkg::spi_state_t                spi_curr_state,
    input  logic [spi_ee_pkg::BIT_CNT_W-1:0]      spi_bit_cnt,
    input  logic [ee_array_pkg::LANE_W-1:0]       spi_byte_cnt,
    input  logic [spi_ee_pkg::BYTE_W-1:0]         usr_byte,
    input  logic                                  preread_state,
    input  logic [ee_array_pkg::EE_WORD_W-1:0]    spi_data_in,
    output logic [ee_array_pkg::EE_WORD_W-1:0]    spi_data_out
);
    import spi_ee_pkg::*;
    import ee_array_pkg::*;

    ee_word_u data_q;       // Word presented to the array
    ee_word_u merged;       // Next word after this byte
    logic     merge_en;     // Byte done in a write state

    assign merge_en = is_wr_state(spi_curr_state) && (spi_bit_cnt == BIT_0);

    // ********************
    // Lane insert
    always_comb begin
        // Background word, fresh array data wins
        merged.word = preread_state ? spi_data_in : data_q.word;
        merged.lane[spi_byte_cnt] = usr_byte;
    end

    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            data_q.word <= '1;                  // Erased word
        end else if (merge_en) begin
            data_q <= merged;
        end
    end

    assign spi_data_out = data_q.word;

endmodule

// File: verilog/ee_wr_cnt.sv
// Page-write byte counter
// Counts written bytes per frame and flags the page roll-over,
// threshold shortened by the lane the write started on
module ee_wr_cnt (
    input  logic                                  spi_clk_c,
    input  logic                                  spi_frm_rst_n,
    input  spi_ee_pkg::spi_state_t                spi_curr_state,
    input  logic [spi_ee_pkg::BIT_CNT_W-1:0]      spi_bit_cnt,
    input  logic [ee_array_pkg::LANE_W-1:0]       lane,
    output logic                                  wr_roll_over
);
    import spi_ee_pkg::*;
    import ee_array_pkg::*;

    logic [WR_CNT_W-1:0] wr_cnt;        // Bytes written so far
    logic [LANE_W-1:0]   start_lane;    // Lane of first byte
    logic [WR_CNT_W-1:0] roll_thr;      // Last byte inside the page

    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            wr_cnt <= '0;
        end else if (is_wr_state(spi_curr_state) && spi_bit_cnt == BIT_0 && !(&wr_cnt)) begin
            wr_cnt <= wr_cnt + 8'd1;            // Holds at all ones
        end
    end

    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            start_lane <= '0;
        end else if (spi_curr_state == SPI_BYTE_WR && spi_bit_cnt == BIT_6) begin
            start_lane <= lane;
        end
    end

    // Unaligned start leaves fewer bytes before the boundary
    assign roll_thr = WR_CNT_W'(PAGE_BYTES - 1) - {{(WR_CNT_W - LANE_W){1'b0}}, start_lane};

    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            wr_roll_over <= 1'b0;
        end else begin
            wr_roll_over <= (wr_cnt >= roll_thr);
        end
    end

endmodule

// File: verilog/spi_din_shift.sv
// Serial data-in shift register
// Collects sda MSB first during write states, byte complete at bit 0
module spi_din_shift (
    input  logic                              spi_clk_c,
    input  logic                              spi_frm_rst_n,
    input  spi_ee_pkg::spi_state_t            spi_curr_state,
    input  logic                              sda_in,
    output logic [spi_ee_pkg::BYTE_W-1:0]     usr_byte
);
    import spi_ee_pkg::*;

    // Bits already taken in this byte, newest in bit 0
    logic [BYTE_W-2:0] din_hist;

    always_ff @(posedge spi_clk_c or negedge spi_frm_rst_n) begin
        if (!spi_frm_rst_n) begin
            din_hist <= '1;                     // Erased pattern
        end else if (is_wr_state(spi_curr_state)) begin
            din_hist <= {din_hist[BYTE_W-3:0], sda_in};  // MSB enters first
        end
    end

    // Live bit closes the byte, valid in the bit 0 cycle
    assign usr_byte = {din_hist, sda_in};

endmodule

// File: verilog/spi_ee_pkg.sv
// SPI EEPROM protocol definitions
// Frame state codes, bit counter positions and serial widths
package spi_ee_pkg;

    localparam int BIT_CNT_W = 3;   // Bit counter, 7 down to 0
    localparam int BYTE_W    = 8;   // One serial byte

    // Frame controller state, codes fixed by the controller
    typedef enum logic [2:0] {
        SPI_CMD     = 3'b000,
        SPI_ADDR_HB = 3'b001,
        SPI_ADDR_LB = 3'b011,
        SPI_BYTE_WR = 3'b010,   // Write states share low bits 10
        SPI_PAGE_WR = 3'b110,
        SPI_DAT_RD  = 3'b111,
        SPI_WAIT    = 3'b101,
        SPI_ERR     = 3'b100
    } spi_state_t;

    // ********************
    // Bit positions within a byte, BIT_0 is the last bit
    localparam logic [BIT_CNT_W-1:0] BIT_0 = 3'd0;
    localparam logic [BIT_CNT_W-1:0] BIT_1 = 3'd1;
    localparam logic [BIT_CNT_W-1:0] BIT_2 = 3'd2;
    localparam logic [BIT_CNT_W-1:0] BIT_3 = 3'd3;
    localparam logic [BIT_CNT_W-1:0] BIT_4 = 3'd4;
    localparam logic [BIT_CNT_W-1:0] BIT_5 = 3'd5;
    localparam logic [BIT_CNT_W-1:0] BIT_6 = 3'd6;
    localparam logic [BIT_CNT_W-1:0] BIT_7 = 3'd7;

    // Byte or page write, decoded from the shared low bits
    function automatic logic is_wr_state(spi_state_t st);
        return st[1:0] == 2'b10;
    endfunction

endpackage

// File: verilog/spi_eebuf_top.sv
// SPI EEPROM slave data buffer
// Byte assembly, address tracking, pre-read, word merge and pump strobes
module spi_eebuf_top (
    input  logic                                  spi_clk_c,
    input  logic                                  spi_frm_rst_n,
    input  spi_ee_pkg::spi_state_t                spi_curr_state,
    input  logic [spi_ee_pkg::BIT_CNT_W-1:0]      spi_bit_cnt,
    input  logic [ee_array_pkg::LANE_W-1:0]       spi_byte_cnt,
    input  logic [ee_array_pkg::EE_ADDR_W-1:0]    spi_curr_addr,
    input  logic                                  sda_in,
    input  logic                                  spi_ee_wbusy,
    input  logic                                  spi_cmd_read,
    input  logic                                  spi_valid,
    input  logic [ee_array_pkg::EE_WORD_W-1:0]    spi_data_in,
    output logic                                  spi_rd_en,
    output logic                                  spi_rdbuf_en,
    output logic                                  spi_cin,
    output logic                                  spi_d_active,
    output logic                                  spi_clr_dl,
    output logic                                  spi_vs_en,
    output logic [ee_array_pkg::EE_ADDR_W-1:0]    spi_ee_addr,
    output logic [ee_array_pkg::EE_WORD_W-1:0]    spi_data_out
);
    import spi_ee_pkg::*;
    import ee_array_pkg::*;

    logic [BYTE_W-1:0] usr_byte;        // Byte complete during bit 0
    logic              preread_state;   // Array word fresh for merge
    logic              wr_roll_over;    // Page boundary reached

    // ********************
    // Serial side
    spi_din_shift u_din_shift (
        .spi_clk_c      (spi_clk_c),
        .spi_frm_rst_n  (spi_frm_rst_n),
        .spi_curr_state (spi_curr_state),
        .sda_in         (sda_in),
        .usr_byte       (usr_byte)
    );

    ee_addr_track u_addr_track (
        .spi_clk_c      (spi_clk_c),
        .spi_frm_rst_n  (spi_frm_rst_n),
        .spi_curr_state (spi_curr_state),
        .spi_bit_cnt    (spi_bit_cnt),
        .spi_curr_addr  (spi_curr_addr),
        .sda_in         (sda_in),
        .spi_ee_wbusy   (spi_ee_wbusy),
        .spi_ee_addr    (spi_ee_addr)
    );

    // ********************
    // Array side
    ee_rd_ctrl u_rd_ctrl (
        .spi_clk_c      (spi_clk_c),
        .spi_frm_rst_n  (spi_frm_rst_n),
        .spi_curr_state (spi_curr_state),
        .spi_bit_cnt    (spi_bit_cnt),
        .lane           (spi_curr_addr[LANE_W-1:0]),
        .spi_cmd_read   (spi_cmd_read),
        .wr_roll_over   (wr_roll_over),
        .spi_rd_en      (spi_rd_en),
        .spi_rdbuf_en   (spi_rdbuf_en),
        .preread_state  (preread_state)
    );

    ee_wr_cnt u_wr_cnt (
        .spi_clk_c      (spi_clk_c),
        .spi_frm_rst_n  (spi_frm_rst_n),
        .spi_curr_state (spi_curr_state),
        .spi_bit_cnt    (spi_bit_cnt),
        .lane           (spi_curr_addr[LANE_W-1:0]),
        .wr_roll_over   (wr_roll_over)
    );

    ee_word_merge u_word_merge (
        .spi_clk_c      (spi_clk_c),
        .spi_frm_rst_n  (spi_frm_rst_n),
        .spi_curr_state (spi_curr_state),
        .spi_bit_cnt    (spi_bit_cnt),
        .spi_byte_cnt   (spi_byte_cnt),
        .usr_byte       (usr_byte),
        .preread_state  (preread_state),
        .spi_data_in    (spi_data_in),
        .spi_data_out   (spi_data_out)
    );

    ee_pump_ctrl u_pump_ctrl (
        .spi_clk_c      (spi_clk_c),
        .spi_frm_rst_n  (spi_frm_rst_n),
        .spi_curr_state (spi_curr_state),
        .spi_bit_cnt    (spi_bit_cnt),
        .spi_valid      (spi_valid),
        .spi_ee_wbusy   (spi_ee_wbusy),
        .spi_cin        (spi_cin),
        .spi_d_active   (spi_d_active),
        .spi_clr_dl     (spi_clr_dl),
        .spi_vs_en      (spi_vs_en)
    );

endmodule
